// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := exec_unit_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)
FAIL_MSG   := SOME TESTS FAILED
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/alu.sv ====
// combinational ALU, selects operand b and computes the decoded integer operation
`timescale 1ns/100ps

module alu (
    input  rv_exec_pkg::decode_t         dec_i,        // op, operand select and immediate
    input  logic [rv_exec_pkg::xlen-1:0] rs1_val_i,    // first bank read
    input  logic [rv_exec_pkg::xlen-1:0] rs2_val_i,    // second bank read
    output logic [rv_exec_pkg::xlen-1:0] result_o
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;                             // low 5 bits only
    logic            lt_signed;
    logic            lt_unsigned;

    assign op_a  = rs1_val_i;
    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_val_i; // imm for OP-IMM and LUI
    assign shamt = op_b[4:0];                           // srai bit 10 is dropped here

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (dec_i.alu_op)
            alu_add: begin
                result_o = op_a + op_b;                 // wraps at 32 bits
            end
            alu_sub: begin
                result_o = op_a - op_b;
            end
            alu_sll: begin
                result_o = op_a << shamt;
            end
            alu_slt: begin
                result_o = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result_o = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result_o = op_a ^ op_b;
            end
            alu_srl: begin
                result_o = op_a >> shamt;               // zero fill
            end
            alu_sra: begin
                result_o = $unsigned($signed(op_a) >>> shamt); // sign fill
            end
            alu_or: begin
                result_o = op_a | op_b;
            end
            alu_and: begin
                result_o = op_a & op_b;
            end
            alu_pass_b: begin
                result_o = op_b;                        // LUI immediate
            end
            default: begin
                result_o = '0;                          // unused encodings
            end
        endcase
    end

endmodule

// ==== design/exec_unit.sv ====
// top of the execute unit, four-phase req/ack controller around decoder, register bank and ALU
`timescale 1ns/100ps

module exec_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_i,         // host request, four-phase
    input  rv_exec_pkg::exec_cmd_t cmd_i,         // stable while req_i is high
    output logic                   ack_o,         // response valid while high
    output rv_exec_pkg::exec_rsp_t rsp_o
);
    import rv_exec_pkg::*;

    typedef enum logic [1:0] {
        st_idle,                                  // waiting for req_i
        st_exec,                                  // decode, read, alu, write back
        st_ack                                    // holding ack until req_i drops
    } state_e;

    state_e          state;
    exec_cmd_t       instr_q;                     // instruction register
    exec_rsp_t       rsp_q;                       // response register
    decode_t         dec;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] alu_result;
    logic            rf_we;                       // one cycle write pulse

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_i) begin
                        state <= st_exec;         // command latched this edge
                    end
                end
                st_exec: begin
                    state <= st_ack;              // write back and ack together
                end
                st_ack: begin
                    if (!req_i) begin
                        state <= st_idle;         // return phase seen
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == st_idle && req_i) begin
            instr_q <= cmd_i;
        end
        if (state == st_exec) begin
            rsp_q.rd      <= dec.rd;
            rsp_q.result  <= dec.illegal ? '0 : alu_result; // no value for an illegal word
            rsp_q.illegal <= dec.illegal;
        end
    end

    // x0 filtering is left to the bank
    assign rf_we = (state == st_exec) && dec.writes_rd;

    assign ack_o = (state == st_ack);             // held through back-pressure
    assign rsp_o = rsp_q;

    instr_decoder i_instr_decoder (
        .instr_i (instr_q),
        .dec_o   (dec)
    );

    regbank i_regbank (
        .clk      (clk),
        .reset    (reset),
        .rs1_i    (dec.rs1),
        .rs2_i    (dec.rs2),
        .rd_i     (dec.rd),
        .we_i     (rf_we),
        .wdata_i  (alu_result),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    alu i_alu (
        .dec_i     (dec),
        .rs1_val_i (rdata1),
        .rs2_val_i (rdata2),
        .result_o  (alu_result)
    );

endmodule

// ==== design/instr_decoder.sv ====
// combinational RV32I decoder for the OP, OP-IMM and LUI subset, flags everything else illegal
`timescale 1ns/100ps

module instr_decoder (
    input  rv_exec_pkg::exec_cmd_t instr_i,     // latched instruction word
    output rv_exec_pkg::decode_t   dec_o        // fields, control and immediate
);
    import rv_exec_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;                        // funct7 all zero
    logic       f7_alt;                         // funct7 is 0100000, sub and sra
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // I type, sign extended from bit 31
    assign imm_i = {{(xlen-12){instr_i[31]}}, instr_i[31:20]};
    // U type, low 12 bits zero
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        dec_o.rs1       = instr_i[19:15];
        dec_o.rs2       = instr_i[24:20];
        dec_o.rd        = instr_i[11:7];
        dec_o.alu_op    = alu_add;
        dec_o.use_imm   = 1'b0;
        dec_o.imm       = imm_i;
        dec_o.writes_rd = 1'b1;
        dec_o.illegal   = 1'b0;

        case (opcode)
            opc_op: begin
                case (funct3)
                    3'b000: dec_o.alu_op = f7_alt ? alu_sub : alu_add;
                    3'b001: dec_o.alu_op = alu_sll;
                    3'b010: dec_o.alu_op = alu_slt;
                    3'b011: dec_o.alu_op = alu_sltu;
                    3'b100: dec_o.alu_op = alu_xor;
                    3'b101: dec_o.alu_op = f7_alt ? alu_sra : alu_srl;
                    3'b110: dec_o.alu_op = alu_or;
                    default: dec_o.alu_op = alu_and;      // funct3 111
                endcase
                // alternate funct7 only allowed on add/sub and srl/sra
                if (!(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
                    dec_o.illegal = 1'b1;
                end
            end

            opc_op_imm: begin
                dec_o.use_imm = 1'b1;
                case (funct3)
                    3'b000: dec_o.alu_op = alu_add;
                    3'b001: begin
                        dec_o.alu_op = alu_sll;
                        dec_o.illegal = !f7_zero;         // slli upper field must be zero
                    end
                    3'b010: dec_o.alu_op = alu_slt;
                    3'b011: dec_o.alu_op = alu_sltu;
                    3'b100: dec_o.alu_op = alu_xor;
                    3'b101: begin
                        dec_o.alu_op = f7_alt ? alu_sra : alu_srl;
                        dec_o.illegal = !(f7_zero || f7_alt);
                    end
                    3'b110: dec_o.alu_op = alu_or;
                    default: dec_o.alu_op = alu_and;
                endcase
            end

            opc_lui: begin
                dec_o.rs1     = '0;                       // field belongs to the immediate
                dec_o.rs2     = '0;
                dec_o.alu_op  = alu_pass_b;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
            end

            default: begin
                dec_o.illegal = 1'b1;                     // opcode outside the subset
            end
        endcase

        if (dec_o.illegal) begin
            dec_o.writes_rd = 1'b0;                       // illegal encodings leave rd alone
        end
    end

endmodule

// ==== design/regbank.sv ====
// 32 x 32 register bank with x0 tied to zero, two combinational reads and one clocked write
`timescale 1ns/100ps

module regbank (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] rs1_i,     // read port 1 index
    input  logic [rv_exec_pkg::reg_addr_w-1:0] rs2_i,     // read port 2 index
    input  logic [rv_exec_pkg::reg_addr_w-1:0] rd_i,      // write index
    input  logic                               we_i,      // single cycle write strobe
    input  logic [rv_exec_pkg::xlen-1:0]       wdata_i,
    output logic [rv_exec_pkg::xlen-1:0]       rdata1_o,
    output logic [rv_exec_pkg::xlen-1:0]       rdata2_o
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] regs [1:num_regs-1];                 // no storage behind x0

    // one clocked word per writable register
    for (genvar i = 1; i < num_regs; i++) begin : gen_reg
        always_ff @(posedge clk) begin
            if (reset) begin
                regs[i] <= '0;                            // bank reads zero after reset
            end else if (we_i && (rd_i == reg_addr_w'(i))) begin
                regs[i] <= wdata_i;                       // visible on reads next cycle
            end
        end
    end

    // shared read decode, index zero yields zero
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] idx);
        logic [xlen-1:0] val;
        val = '0;
        if (idx != '0) begin
            val = regs[idx];                              // writes to x0 never land here
        end
        return val;
    endfunction

    always_comb begin
        rdata1_o = read_port(rs1_i);                      // port 1, combinational
    end

    always_comb begin
        rdata2_o = read_port(rs2_i);                      // port 2, combinational
    end

endmodule

// ==== design/rv_exec_pkg.sv ====
// shared widths, opcode values, alu op encoding and command/response structs for the execute unit
package rv_exec_pkg;

    localparam int xlen       = 32;                 // data word width
    localparam int reg_addr_w = 5;                  // register index width
    localparam int num_regs   = 32;                 // x0 included

    // major opcodes of the kept RV32I subset
    localparam logic [6:0] opc_op     = 7'b0110011; // register-register
    localparam logic [6:0] opc_op_imm = 7'b0010011; // register-immediate
    localparam logic [6:0] opc_lui    = 7'b0110111; // load upper immediate

    // alu operation select, 4 bits wide
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,                          // signed compare
        alu_sltu   = 4'd4,                          // unsigned compare
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,                          // sign fill
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10                          // second operand straight through, LUI
    } alu_op_e;

    // host command is one raw instruction word
    typedef logic [xlen-1:0] exec_cmd_t;

    // decoder output, consumed by the regbank read ports, the alu and the controller
    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;                 // first source index
        logic [reg_addr_w-1:0] rs2;                 // second source index
        logic [reg_addr_w-1:0] rd;                  // destination index
        alu_op_e               alu_op;
        logic                  use_imm;             // operand b from imm instead of rs2
        logic [xlen-1:0]       imm;                 // already sign extended or shifted
        logic                  writes_rd;           // result goes back to the bank
        logic                  illegal;             // encoding outside the subset
    } decode_t;

    // response returned to the host while ack is high
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;                  // destination of the command
        logic [xlen-1:0]       result;              // alu value
        logic                  illegal;             // nothing was written
    } exec_rsp_t;

endpackage

// ==== src.f ====
design/rv_exec_pkg.sv
design/regbank.sv
design/instr_decoder.sv
design/alu.sv
design/exec_unit.sv
test/exec_unit_checker.sv
test/exec_unit_tb.sv

// ==== test/exec_golden.txt ====
# one command per line in execution order
# name instr result illegal
add_reset        002082b3 00000000 0
addi_x1          06400093 00000064 0
addi_x2_neg      ff900113 fffffff9 0
lui_x3           123451b7 12345000 0
addi_x3_lo       67818193 12345678 0
lui_x4           80000237 80000000 0
add_x5           002082b3 0000005d 0
sub_neg          40110333 ffffff95 0
sub_wrap         401203b3 7fffff9c 0
and_x8           0011f433 00000060 0
or_x9            0041e4b3 92345678 0
xor_x10          0021c533 edcba981 0
slt_neg          001125b3 00000001 0
sltu_neg         00113633 00000000 0
slt_both_neg     002226b3 00000001 0
slti_neg         fff12713 00000001 0
sltiu_max        fff0b793 00000001 0
xori_not         fff0c813 ffffff9b 0
ori_x17          7000e893 00000764 0
andi_x18         0f01f913 00000070 0
sll_reg          002099b3 c8000000 0
srl_reg          00225a33 00000040 0
sra_neg          40225ab3 ffffffc0 0
sra_pos          40f1db33 091a2b3c 0
slli_0           00019b93 12345678 0
slli_31          01f79c13 80000000 0
srli_31          01f25c93 00000001 0
srai_31          41f25d13 ffffffff 0
srai_0           400add93 ffffffc0 0
srli_0           00085e13 ffffff9b 0
addi_x0          00500013 00000005 0
add_x0_src       00100eb3 00000064 0
bad_opcode       000000ff 00000000 1
read_x1          00008f13 00000064 0
bad_funct7       022082b3 00000000 1
read_x5          00028f93 0000005d 0
bad_slli         40109313 00000000 1
read_x6          000303b3 ffffff95 0

// ==== test/exec_unit_checker.sv ====
// handshake and write-back assertions, attached to every exec_unit instance through bind
`timescale 1ns/100ps

module exec_unit_checker (
    input logic clk,
    input logic reset,
    input logic req_i,                          // host request
    input logic ack_i,                          // ack_o of the unit
    input logic we_i,                           // regbank write strobe
    input logic illegal_i                       // decoder illegal flag
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack_i) |-> req_i)
        else $error("ack_o rose while req_i was low");

    // back-pressure keeps the acknowledge up
    ack_holds: assert property (@(posedge clk) disable iff (reset)
        (ack_i && req_i) |=> ack_i)
        else $error("ack_o fell while req_i was still high");

    // one write per accepted command
    single_write: assert property (@(posedge clk) disable iff (reset)
        we_i |=> !we_i)
        else $error("register write enable high for two cycles in a row");

    // an illegal word never reaches the bank
    no_illegal_write: assert property (@(posedge clk) disable iff (reset)
        we_i |-> !illegal_i)
        else $error("register write enable high for an illegal instruction");

endmodule

bind exec_unit exec_unit_checker i_exec_unit_checker (
    .clk       (clk),
    .reset     (reset),
    .req_i     (req_i),
    .ack_i     (ack_o),
    .we_i      (rf_we),                         // internal write pulse
    .illegal_i (dec.illegal)
);

// ==== test/exec_unit_tb.sv ====
// self-checking testbench for exec_unit that replays the golden command list over four-phase req/ack
`timescale 1ns/100ps

module exec_unit_tb;
    import rv_exec_pkg::*;

    typedef struct packed {
        logic [8*24-1:0] name;                  // ascii test name
        exec_cmd_t       instr;                 // word sent to the unit
        exec_rsp_t       rsp;                   // expected response
    } golden_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        req;
    exec_cmd_t   cmd;
    logic        ack;
    exec_rsp_t   rsp;

    golden_t     golden_q[$];                   // commands in file order
    logic [31:0] lfsr_state = 32'hb59b2c20;     // delay generator
    int          cycle_count = 0;
    int          cycle_limit = 50;              // raised once the file is read

    always #50 clk = ~clk;                      // 100 ns period

    exec_unit i_exec_unit (
        .clk   (clk),
        .reset (reset),
        .req_i (req),
        .cmd_i (cmd),
        .ack_o (ack),
        .rsp_o (rsp)
    );

    // ends the run with the fail message
    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the command list did not complete", cycle_count);
            stop_on_failure();
        end
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | {31'd0, lfsr_state[0]};
        end
    endtask

    task automatic read_golden();
        int               fd;
        int               fields;
        logic [8*160-1:0] line_buf;
        logic [8*24-1:0]  name;
        logic [31:0]      instr;
        logic [31:0]      result;
        logic [31:0]      illegal;
        golden_t          entry;
        fd = $fopen("test/exec_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/exec_golden.txt");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) != 0) begin
                fields = $sscanf(line_buf, "%s %h %h %h", name, instr, result, illegal);
                if (fields == 4) begin                  // header and blank lines fall out here
                    entry.name        = name;
                    entry.instr       = instr;
                    entry.rsp.rd      = instr[11:7];    // rd field of every format
                    entry.rsp.result  = result;
                    entry.rsp.illegal = illegal[0];
                    golden_q.push_back(entry);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_rsp(input logic [8*24-1:0] name, input exec_rsp_t exp,
                               input exec_rsp_t act);
        string act_text;
        if (act !== exp) begin
            act_text = $sformatf("rd=%0d result=%h illegal=%b", act.rd, act.result, act.illegal);
            $display("FAILED %0s expected rd=%0d result=%h illegal=%b actual %0s",
                     name, exp.rd, exp.result, exp.illegal, act_text);
            stop_on_failure();
        end
    endtask

    task automatic compare_ack_timing(input logic [8*24-1:0] name, input int exp_edges,
                                      input int act_edges);
        if (act_edges != exp_edges) begin
            $display("FAILED %0s ack edges expected %0d actual %0d", name, exp_edges, act_edges);
            stop_on_failure();
        end
    endtask

    // counts rising edges until ack reaches level and samples ack on the falling edge
    task automatic wait_for_ack(input logic level, input logic [8*24-1:0] name,
                                output int edges);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (ack !== level && edges < 6);
        if (ack !== level) begin
            $display("%0s ack_o did not go to %b within %0d cycles", name, level, edges);
            stop_on_failure();
        end
    endtask

    initial begin
        int idle;
        int hold;
        int edges;
        reset = 1'b1;
        req   = 1'b0;
        cmd   = '0;
        read_golden();
        cycle_limit = golden_q.size() * 10 + 50;     // at most 10 edges per command
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (golden_q[i]) begin
            draw_bits(2, idle);                      // 0 to 3 idle cycles
            draw_bits(1, hold);                      // back-pressure on about half the lines
            repeat (idle) @(posedge clk);
            @(posedge clk);
            req <= 1'b1;
            cmd <= golden_q[i].instr;
            wait_for_ack(1'b1, golden_q[i].name, edges);
            compare_ack_timing(golden_q[i].name, 2, edges);
            compare_rsp(golden_q[i].name, golden_q[i].rsp, rsp);
            repeat (hold * 2) begin                  // response must not move while req stays high
                @(posedge clk);
                @(negedge clk);
                if (ack !== 1'b1) begin
                    $display("%0s ack_o dropped while req_i was still high", golden_q[i].name);
                    stop_on_failure();
                end
                compare_rsp(golden_q[i].name, golden_q[i].rsp, rsp);
            end
            @(posedge clk);
            req <= 1'b0;                             // return phase
            wait_for_ack(1'b0, golden_q[i].name, edges);
            compare_ack_timing(golden_q[i].name, 1, edges);
        end
        @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
